// ==== dbg_dump.f ====
+incdir+logic
logic/dbg_dump_pkg.sv
logic/dump_item_if.sv
logic/dump_sequencer.sv
logic/dump_formatter.sv
logic/dbg_dump.sv
test/dbg_dump_tb.sv

// ==== Bender.yml ====
package:
  name: dbg_dump

sources:
  - include_dirs:
      - logic
    files:
      - logic/dbg_dump_pkg.sv
      - logic/dump_item_if.sv
      - logic/dump_sequencer.sv
      - logic/dump_formatter.sv
      - logic/dbg_dump.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/dbg_dump_tb.sv

// ==== test/dbg_dump_tb.sv ====
`timescale 1ns/1ns
`include "dbg_dump_defs.svh"

module dbg_dump_tb;
    import dbg_dump_pkg::*;

    localparam int NUM_TESTS  = 6;
    localparam int DUMP_ITEMS = 39;

    typedef struct packed {
        logic [`DD_SEL_W-1:0]                      sel_mode;
        logic [`DD_SEL_W-1:0]                      cmd;
        logic [`DD_NUM_FIELDS-1:0][`DD_WORD_W-1:0] vals;
        int                                        abort_pos;   // -1 for no abort
        int                                        dumps;
    } test_entry_t;

    logic                  clk;
    logic                  rstn;
    logic [`DD_SEL_W-1:0]  sel_mode;
    logic [`DD_SEL_W-1:0]  cmd;
    logic [`DD_WORD_W-1:0] npc, pc, ir, ctl, a, b, imm, y, mdr;
    logic                  ack;
    logic                  req;
    tx_kind_e              kind;
    logic [`DD_WORD_W-1:0] dout;
    logic                  finish;

    test_entry_t tests [NUM_TESTS];
    tx_kind_e    exp_kind [DUMP_ITEMS];
    tx_word_u    exp_word [DUMP_ITEMS];
    string       labels [`DD_NUM_FIELDS];
    logic [31:0] rng;
    int          errors, pass_cnt, fail_cnt, cycles, cycle_limit;

    dbg_dump dut_i (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: transmitter never finished the dump");
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic tx_word_u char_word(input logic [`DD_CHAR_W-1:0] ch);
        tx_word_u w;
        w        = '0;
        w.chr.ch = ch;
        return w;
    endfunction

    task automatic compare_word(input string name, input tx_word_u exp_v, input tx_word_u act_v);
        if (act_v !== exp_v) begin
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic compare_kind(input string name, input tx_kind_e exp_v, input tx_kind_e act_v);
        if (act_v !== exp_v) begin
            $display("Mismatch at %0t ns: %s expected %b, got %b", $time, name, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic compare_bit(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("Mismatch at %0t ns: %s expected %b, got %b", $time, name, exp_v, act_v);
            errors++;
        end
    endtask

    // Labels, "=", raw word per field, then line end
    task automatic build_stream(input test_entry_t e);
        int n;
        n = 0;
        for (int f = 0; f < `DD_NUM_FIELDS; f++) begin
            for (int c = 0; c < labels[f].len(); c++) begin
                exp_kind[n] = CHAR;
                exp_word[n] = char_word(labels[f][c]);
                n++;
            end
            exp_kind[n]   = CHAR;
            exp_word[n]   = char_word(`DD_ASCII_EQ);
            exp_kind[n+1] = WORD;
            exp_word[n+1] = e.vals[f];
            n += 2;
        end
        exp_kind[n]   = CHAR;
        exp_word[n]   = char_word(`DD_ASCII_CR);
        exp_kind[n+1] = CHAR;
        exp_word[n+1] = char_word(`DD_ASCII_LF);
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            pass_cnt++;
            $display("%s: ok", name);
        end else begin
            fail_cnt++;
            $display("%s: %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic run_test(input int t);
        test_entry_t e;
        int          pos, dumps_done, wait_cnt, hold, errs_before;
        logic        aborted, prev_accept, prev_lf;
        e           = tests[t];
        errs_before = errors;
        pos         = 0;
        dumps_done  = 0;
        hold        = 0;
        aborted     = 1'b0;
        prev_accept = 1'b0;
        prev_lf     = 1'b0;
        build_stream(e);
        rng      = lcg(rng);
        wait_cnt = rng[17:16];
        @(negedge clk);
        sel_mode = e.sel_mode;
        cmd      = e.cmd;
        {mdr, y, imm, b, a, ctl, ir, pc, npc} = e.vals;
        if (e.sel_mode != e.cmd) begin
            repeat (20) begin
                @(negedge clk);
                compare_bit("req", 1'b0, req);
                compare_bit("finish", 1'b0, finish);
                rng = lcg(rng);
                ack = rng[20];   // Stray ack, no request
            end
            ack = 1'b0;
        end else begin
            while (dumps_done < e.dumps || prev_accept) begin
                @(negedge clk);
                compare_bit("finish", prev_lf, finish);
                if (prev_accept || hold > 0)
                    compare_bit("req", 1'b0, req);
                prev_accept = 1'b0;
                prev_lf     = 1'b0;
                ack         = 1'b0;
                if (hold > 0) begin
                    hold--;
                    if (hold == 0) begin
                        sel_mode = e.cmd;   // Match again, stream restarts
                        pos      = 0;
                    end
                end else if (!aborted && pos == e.abort_pos) begin
                    sel_mode = ~e.cmd;
                    aborted  = 1'b1;
                    hold     = 3;
                end else if (req === 1'b1) begin
                    compare_kind("kind", exp_kind[pos], kind);
                    compare_word("dout", exp_word[pos], dout);
                    if (wait_cnt == 0) begin
                        ack         = 1'b1;
                        prev_accept = 1'b1;
                        rng         = lcg(rng);
                        wait_cnt    = rng[17:16];
                        if (pos == DUMP_ITEMS - 1) begin
                            prev_lf = 1'b1;
                            dumps_done++;
                            pos = 0;
                        end else begin
                            pos++;
                        end
                    end else begin
                        wait_cnt--;
                    end
                end else begin
                    rng = lcg(rng);
                    ack = rng[20];   // Must not advance the stream
                end
            end
            sel_mode = ~e.cmd;   // Cut off the dump that follows
            ack      = 1'b0;
            @(negedge clk);
            compare_bit("req", 1'b0, req);
            compare_bit("finish", 1'b0, finish);
        end
        report_test($sformatf("Test %0d", t), errs_before);
    endtask

    initial begin
        int errs_before;
        clk      = 1'b0;
        rstn     = 1'b0;
        ack      = 1'b0;
        sel_mode = 8'h00;
        cmd      = 8'h01;
        {mdr, y, imm, b, a, ctl, ir, pc, npc} = '0;
        errors   = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        cycles   = 0;
        rng      = 32'h9c00;
        labels   = '{"NPC", "PC", "IR", "CTL", "A", "B", "IMM", "Y", "MDR"};
        // sel_mode, cmd, values, abort position, complete dumps
        tests[0] = '{8'h10, 8'hD5, '0, -1, 0};
        tests[1] = '{8'hD5, 8'hD5, '0, -1, 1};
        tests[2] = '{8'h3A, 8'h3A, '0, -1, 2};
        tests[3] = '{8'hD5, 8'hD5, '0, 14, 1};
        tests[4] = '{8'h00, 8'h01, '0, -1, 0};
        tests[5] = '{8'hFF, 8'hFF, '0, 37, 1};
        cycle_limit = 100;
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int f = 0; f < `DD_NUM_FIELDS; f++) begin
                rng              = lcg(rng);
                tests[t].vals[f] = rng;
            end
            cycle_limit += tests[t].dumps * DUMP_ITEMS * 6;
        end
        tests[1].vals[0] = 32'hFFFF_FFFF;
        tests[1].vals[8] = 32'h0000_0000;
        repeat (2) @(negedge clk);
        rstn        = 1'b1;
        errs_before = errors;
        repeat (3) begin
            @(negedge clk);
            compare_bit("req", 1'b0, req);
            compare_bit("finish", 1'b0, finish);
        end
        report_test("Reset", errs_before);
        for (int t = 0; t < NUM_TESTS; t++)
            run_test(t);
        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== logic/dbg_dump.sv ====
`timescale 1ns/1ns
`include "dbg_dump_defs.svh"

module dbg_dump (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [`DD_SEL_W-1:0]   sel_mode,
    input  logic [`DD_SEL_W-1:0]   cmd,
    input  logic [`DD_WORD_W-1:0]  npc,
    input  logic [`DD_WORD_W-1:0]  pc,
    input  logic [`DD_WORD_W-1:0]  ir,
    input  logic [`DD_WORD_W-1:0]  ctl,
    input  logic [`DD_WORD_W-1:0]  a,
    input  logic [`DD_WORD_W-1:0]  b,
    input  logic [`DD_WORD_W-1:0]  imm,
    input  logic [`DD_WORD_W-1:0]  y,
    input  logic [`DD_WORD_W-1:0]  mdr,
    input  logic                   ack,
    output logic                   req,
    output dbg_dump_pkg::tx_kind_e kind,
    output logic [`DD_WORD_W-1:0]  dout,
    output logic                   finish
);
    import dbg_dump_pkg::*;

    tx_word_u tx_word;

    dump_item_if item_if ();

    dump_sequencer seq_i (
        .clk      (clk),
        .rstn     (rstn),
        .sel_mode (sel_mode),
        .cmd      (cmd),
        .ack      (ack),
        .item     (item_if.seq),
        .req      (req),
        .finish   (finish)
    );

    dump_formatter fmt_i (
        .item (item_if.fmt),
        .npc  (npc),
        .pc   (pc),
        .ir   (ir),
        .ctl  (ctl),
        .a    (a),
        .b    (b),
        .imm  (imm),
        .y    (y),
        .mdr  (mdr),
        .kind (kind),
        .word (tx_word)
    );

    assign dout = tx_word.data;   // Transmitter decodes by kind

endmodule

// ==== logic/dump_formatter.sv ====
`timescale 1ns/1ns
`include "dbg_dump_defs.svh"

module dump_formatter (
    dump_item_if.fmt              item,
    input  logic [`DD_WORD_W-1:0] npc,
    input  logic [`DD_WORD_W-1:0] pc,
    input  logic [`DD_WORD_W-1:0] ir,
    input  logic [`DD_WORD_W-1:0] ctl,
    input  logic [`DD_WORD_W-1:0] a,
    input  logic [`DD_WORD_W-1:0] b,
    input  logic [`DD_WORD_W-1:0] imm,
    input  logic [`DD_WORD_W-1:0] y,
    input  logic [`DD_WORD_W-1:0] mdr,
    output dbg_dump_pkg::tx_kind_e kind,
    output dbg_dump_pkg::tx_word_u word
);
    import dbg_dump_pkg::*;

    logic [`DD_LABEL_MAX*`DD_CHAR_W-1:0] label_text;
    logic [`DD_CHAR_W-1:0]               label_char;
    char_idx_t                           last_idx;
    logic [`DD_WORD_W-1:0]               field_val;

    // Labels left aligned, unused characters zero
    always_comb begin
        case (item.field)
            F_NPC:   label_text = "NPC";
            F_PC:    label_text = {"PC", 8'h00};
            F_IR:    label_text = {"IR", 8'h00};
            F_CTL:   label_text = "CTL";
            F_A:     label_text = {"A", 16'h0000};
            F_B:     label_text = {"B", 16'h0000};
            F_IMM:   label_text = "IMM";
            F_Y:     label_text = {"Y", 16'h0000};
            default: label_text = "MDR";
        endcase
    end

    always_comb begin
        case (item.field)
            F_A, F_B, F_Y: last_idx = 2'd0;
            F_PC, F_IR:    last_idx = 2'd1;
            default:       last_idx = 2'd2;   // Three-letter labels
        endcase
    end

    assign label_char      = label_text[(`DD_LABEL_MAX - 1 - item.char_idx) * `DD_CHAR_W +:
                                        `DD_CHAR_W];
    assign item.label_last = (item.char_idx == last_idx);

    always_comb begin
        case (item.field)
            F_NPC:   field_val = npc;
            F_PC:    field_val = pc;
            F_IR:    field_val = ir;
            F_CTL:   field_val = ctl;
            F_A:     field_val = a;
            F_B:     field_val = b;
            F_IMM:   field_val = imm;
            F_Y:     field_val = y;
            default: field_val = mdr;
        endcase
    end

    always_comb begin
        word = '0;
        kind = CHAR;
        case (item.phase)
            LABEL:  word.chr.ch = label_char;
            EQUALS: word.chr.ch = `DD_ASCII_EQ;
            DATA: begin
                kind      = WORD;   // Raw register value
                word.data = field_val;
            end
            CR:      word.chr.ch = `DD_ASCII_CR;
            LF:      word.chr.ch = `DD_ASCII_LF;
            default: word = '0;
        endcase
    end

endmodule

// ==== logic/dump_sequencer.sv ====
`timescale 1ns/1ns
`include "dbg_dump_defs.svh"

module dump_sequencer (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic [`DD_SEL_W-1:0] sel_mode,
    input  logic [`DD_SEL_W-1:0] cmd,
    input  logic                 ack,
    dump_item_if.seq             item,
    output logic                 req,
    output logic                 finish
);
    import dbg_dump_pkg::*;

    logic      match;
    logic      accept;
    logic      last_field;
    phase_e    phase_q;
    phase_e    phase_d;
    field_e    field_q;
    field_e    field_d;
    char_idx_t idx_q;
    char_idx_t idx_d;

    assign match      = (sel_mode == cmd);
    assign accept     = req && ack;   // Ack without req is ignored
    assign last_field = (field_q == field_e'(`DD_NUM_FIELDS - 1));

    // Next item after an acceptance
    always_comb begin
        phase_d = phase_q;
        field_d = field_q;
        idx_d   = idx_q;
        if (phase_q == IDLE) begin
            phase_d = LABEL;   // Start of a new dump
            field_d = F_NPC;
            idx_d   = '0;
        end else if (accept) begin
            case (phase_q)
                LABEL: begin
                    if (item.label_last) begin
                        phase_d = EQUALS;
                        idx_d   = '0;
                    end else begin
                        idx_d = idx_q + 1'b1;
                    end
                end
                EQUALS: begin
                    phase_d = DATA;
                end
                DATA: begin
                    if (last_field) begin
                        phase_d = CR;
                    end else begin
                        phase_d = LABEL;
                        field_d = field_e'(field_q + 1'b1);
                    end
                end
                CR: begin
                    phase_d = LF;
                end
                LF: begin
                    phase_d = IDLE;   // Line done
                    field_d = F_NPC;
                end
                default: begin
                    phase_d = IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase_q <= IDLE;
            field_q <= F_NPC;
            idx_q   <= '0;
            req     <= 1'b0;
            finish  <= 1'b0;
        end else if (!match) begin
            // Abort, next match starts from the first character
            phase_q <= IDLE;
            field_q <= F_NPC;
            idx_q   <= '0;
            req     <= 1'b0;
            finish  <= 1'b0;
        end else begin
            phase_q <= phase_d;
            field_q <= field_d;
            idx_q   <= idx_d;
            req     <= (phase_q != IDLE) && !accept;   // One-cycle gap after ack
            finish  <= accept && (phase_q == LF);
        end
    end

    assign item.field    = field_q;
    assign item.phase    = phase_q;
    assign item.char_idx = idx_q;

endmodule

// ==== logic/dump_item_if.sv ====
`timescale 1ns/1ns

interface dump_item_if;
    import dbg_dump_pkg::*;

    field_e    field;      // Register being printed
    phase_e    phase;
    char_idx_t char_idx;   // Position inside the label
    logic      label_last;

    modport seq (
        output field,
        output phase,
        output char_idx,
        input  label_last
    );

    modport fmt (
        input  field,
        input  phase,
        input  char_idx,
        output label_last
    );

endinterface

// ==== logic/dbg_dump_pkg.sv ====
`include "dbg_dump_defs.svh"

package dbg_dump_pkg;

    // Print order of the datapath registers
    typedef enum logic [3:0] {
        F_NPC,
        F_PC,
        F_IR,
        F_CTL,
        F_A,
        F_B,
        F_IMM,
        F_Y,
        F_MDR
    } field_e;

    typedef enum logic [2:0] {
        IDLE,
        LABEL,
        EQUALS,
        DATA,
        CR,
        LF
    } phase_e;

    // Type flag seen by the transmitter
    typedef enum logic {
        CHAR = 1'b0,
        WORD = 1'b1
    } tx_kind_e;

    // Same word read as raw data or as a single character
    typedef union packed {
        logic [`DD_WORD_W-1:0] data;
        struct packed {
            logic [`DD_WORD_W-`DD_CHAR_W-1:0] pad;
            logic [`DD_CHAR_W-1:0]            ch;
        } chr;
    } tx_word_u;

    typedef logic [1:0] char_idx_t;

endpackage

// ==== logic/dbg_dump_defs.svh ====
`ifndef DBG_DUMP_DEFS_SVH
`define DBG_DUMP_DEFS_SVH

// Transmit word and character widths
`define DD_WORD_W 32
`define DD_CHAR_W 8

// Mode select and command code width
`define DD_SEL_W 8

// Printed register set
`define DD_NUM_FIELDS 9
`define DD_LABEL_MAX 3

// ASCII codes for the separators
`define DD_ASCII_EQ 8'h3D
`define DD_ASCII_CR 8'h0D
`define DD_ASCII_LF 8'h0A

`endif
